/* Bender.yml */
package:
  name: rv_core

sources:
  - rv_soc_pkg.sv
  - rv_isa_pkg.sv
  - rv_fetch_decode.sv
  - rv_regfile.sv
  - rv_execute.sv
  - rv_lsu_apb.sv
  - rv_core.sv
  - target: test
    files:
      - tb_rv_core_assert.sv
      - tb_rv_core.sv

/* rv_core.f */
rv_soc_pkg.sv
rv_isa_pkg.sv
rv_fetch_decode.sv
rv_regfile.sv
rv_execute.sv
rv_lsu_apb.sv
rv_core.sv
tb_rv_core_assert.sv
tb_rv_core.sv

/* rv_core.sv */
`timescale 1ns/100ps

module rv_core (
  input  logic              clk,
  input  logic              reset,
  output rv_soc_pkg::addr_t imem_addr,
  input  rv_soc_pkg::word_t imem_rdata,
  output rv_soc_pkg::addr_t paddr,
  output logic              psel,
  output logic              penable,
  output logic              pwrite,
  output rv_soc_pkg::word_t pwdata,
  input  rv_soc_pkg::word_t prdata,
  input  logic              pready,
  output logic              halt
);
  import rv_soc_pkg::*;
  import rv_isa_pkg::*;

  reg_idx_t   rs1;
  reg_idx_t   rs2;
  reg_idx_t   rd;
  logic       rd_we;
  word_t      rd_wdata;
  word_t      rs1_data;
  word_t      rs2_data;
  alu_op_t    alu_op;
  logic       op_a_pc;
  logic       op_b_imm;
  word_t      imm;
  addr_t      pc;
  logic [2:0] funct3;
  logic       is_branch;
  word_t      alu_result;
  logic       branch_taken;
  logic       mem_req;
  logic       mem_write;
  logic       mem_done;
  word_t      load_data;

  rv_fetch_decode i_fetch_decode (
    .clk          (clk),
    .reset        (reset),
    .imem_addr    (imem_addr),
    .imem_rdata   (imem_rdata),
    .rs1          (rs1),
    .rs2          (rs2),
    .rd           (rd),
    .rd_we        (rd_we),
    .rd_wdata     (rd_wdata),
    .alu_op       (alu_op),
    .op_a_pc      (op_a_pc),
    .op_b_imm     (op_b_imm),
    .imm          (imm),
    .pc           (pc),
    .funct3       (funct3),
    .is_branch    (is_branch),
    .alu_result   (alu_result),
    .branch_taken (branch_taken),
    .mem_req      (mem_req),
    .mem_write    (mem_write),
    .mem_done     (mem_done),
    .load_data    (load_data),
    .halt         (halt)
  );

  rv_regfile i_regfile (
    .clk      (clk),
    .reset    (reset),
    .rs1      (rs1),
    .rs2      (rs2),
    .rd       (rd),
    .rd_we    (rd_we),
    .rd_wdata (rd_wdata),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  rv_execute i_execute (
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .pc           (pc),
    .imm          (imm),
    .alu_op       (alu_op),
    .op_a_pc      (op_a_pc),
    .op_b_imm     (op_b_imm),
    .funct3       (funct3),
    .is_branch    (is_branch),
    .alu_result   (alu_result),
    .branch_taken (branch_taken)
  );

  // effective address comes from the alu, store data from rs2
  rv_lsu_apb i_lsu_apb (
    .clk        (clk),
    .reset      (reset),
    .mem_req    (mem_req),
    .mem_write  (mem_write),
    .mem_addr   (alu_result),
    .store_data (rs2_data),
    .mem_done   (mem_done),
    .load_data  (load_data),
    .paddr      (paddr),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pready     (pready)
  );

endmodule

/* rv_core_golden.txt */
// @000 program word count, then instruction words from pc 0, four per line
// @100 data word count, then address/word pairs; @180 store count, then address/data pairs
@000
00000038
20000093 FFB00113 00700193 00310233
0040A023 402182B3 0050A223 00319333
0060A423 40115393 0070A623 01C15413
0080A823 003124B3 00313533 0090AA23
00A0AC23 0F01C593 0025E633 03C17693
00B0AE23 02C0A023 02D0A223 ABCDE737
00001797 02E0A423 02F0A623 00518013
0200A823 00318463 0230AA23 00319463
00314463 0230AC23 00315463 0021E463
0230AE23 0021F463 0080086F 0430A023
0300AA23 0B400893 00588967 0430A223
0430A423 0430A623 0320AC23 1000A983
1040AA03 01498AB3 0350AE23 0200AB03
004B5B93 0570A023 0530A223 00000073
// initial data memory
@100
00000002
00000300 12345678 00000304 80000001
// expected stores in order
@180
00000012
00000200 00000002 00000204 0000000C
00000208 00000380 0000020C FFFFFFFD
00000210 0000000F 00000214 00000001
00000218 00000000 0000021C 000000F7
00000220 FFFFFFFF 00000224 00000038
00000228 ABCDE000 0000022C 00001060
00000230 00000000 00000234 0000009C
00000238 000000AC 0000023C 92345679
00000240 0FFFFFFF 00000244 12345678
// halt pc
@1FF
000000DC

/* rv_execute.sv */
`timescale 1ns/100ps

module rv_execute (
  input  rv_soc_pkg::word_t   rs1_data,
  input  rv_soc_pkg::word_t   rs2_data,
  input  rv_soc_pkg::addr_t   pc,
  input  rv_soc_pkg::word_t   imm,
  input  rv_isa_pkg::alu_op_t alu_op,
  input  logic                op_a_pc,
  input  logic                op_b_imm,
  input  logic [2:0]          funct3,
  input  logic                is_branch,
  output rv_soc_pkg::word_t   alu_result,
  output logic                branch_taken
);
  import rv_soc_pkg::*;
  import rv_isa_pkg::*;

  word_t      op_a;
  word_t      op_b;
  logic [4:0] shamt;
  logic       cond;

  assign op_a  = op_a_pc ? pc : rs1_data;
  assign op_b  = op_b_imm ? imm : rs2_data;
  assign shamt = op_b[4:0];

  always_comb begin
    case (alu_op)
      ALU_ADD:    alu_result = op_a + op_b;
      ALU_SUB:    alu_result = op_a - op_b;
      ALU_SLL:    alu_result = op_a << shamt;
      ALU_SLT:    alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
      ALU_SLTU:   alu_result = {31'b0, op_a < op_b};
      ALU_XOR:    alu_result = op_a ^ op_b;
      ALU_SRL:    alu_result = op_a >> shamt;
      ALU_SRA:    alu_result = $signed(op_a) >>> shamt;
      ALU_OR:     alu_result = op_a | op_b;
      ALU_AND:    alu_result = op_a & op_b;
      ALU_PASS_B: alu_result = op_b;
      default:    alu_result = op_a + op_b;
    endcase
  end

  // branch compare always on the two register values
  always_comb begin
    case (funct3)
      F3_BEQ:  cond = (rs1_data == rs2_data);
      F3_BNE:  cond = (rs1_data != rs2_data);
      F3_BLT:  cond = ($signed(rs1_data) < $signed(rs2_data));
      F3_BGE:  cond = ($signed(rs1_data) >= $signed(rs2_data));
      F3_BLTU: cond = (rs1_data < rs2_data);
      F3_BGEU: cond = (rs1_data >= rs2_data);
      default: cond = 1'b0;
    endcase
  end

  assign branch_taken = is_branch && cond;

endmodule

/* rv_fetch_decode.sv */
`timescale 1ns/100ps

module rv_fetch_decode (
  input  logic                 clk,
  input  logic                 reset,
  output rv_soc_pkg::addr_t    imem_addr,
  input  rv_soc_pkg::word_t    imem_rdata,
  output rv_soc_pkg::reg_idx_t rs1,
  output rv_soc_pkg::reg_idx_t rs2,
  output rv_soc_pkg::reg_idx_t rd,
  output logic                 rd_we,
  output rv_soc_pkg::word_t    rd_wdata,
  output rv_isa_pkg::alu_op_t  alu_op,
  output logic                 op_a_pc,
  output logic                 op_b_imm,
  output rv_soc_pkg::word_t    imm,
  output rv_soc_pkg::addr_t    pc,
  output logic [2:0]           funct3,
  output logic                 is_branch,
  input  rv_soc_pkg::word_t    alu_result,
  input  logic                 branch_taken,
  output logic                 mem_req,
  output logic                 mem_write,
  input  logic                 mem_done,
  input  rv_soc_pkg::word_t    load_data,
  output logic                 halt
);
  import rv_soc_pkg::*;
  import rv_isa_pkg::*;

  logic [1:0] state;
  instr_u     ir;
  addr_t      pc_plus4;
  addr_t      next_pc;
  wb_sel_t    wb_sel;
  logic       reg_write;
  logic       is_load;
  logic       is_store;
  logic       is_jal;
  logic       is_jalr;
  logic       is_ecall;

  // alt selects SUB or SRA, SUB only exists in register form
  function automatic alu_op_t alu_from_funct(input logic [2:0] f3, input logic alt,
                                             input logic reg_form);
    case (f3)
      F3_ADD_SUB: return (alt && reg_form) ? ALU_SUB : ALU_ADD;
      F3_SLL:     return ALU_SLL;
      F3_SLT:     return ALU_SLT;
      F3_SLTU:    return ALU_SLTU;
      F3_XOR:     return ALU_XOR;
      F3_SRL_SRA: return alt ? ALU_SRA : ALU_SRL;
      F3_OR:      return ALU_OR;
      default:    return ALU_AND;
    endcase
  endfunction

  assign imem_addr = pc;
  assign pc_plus4  = pc + 32'd4;
  assign rs1       = ir.r.rs1;
  assign rs2       = ir.r.rs2;
  assign rd        = ir.r.rd;
  assign funct3    = ir.r.funct3;
  assign halt      = (state == CORE_HALT);

  // opcode decode
  always_comb begin
    alu_op    = ALU_ADD;
    op_a_pc   = 1'b0;
    op_b_imm  = 1'b1;
    imm       = {{20{ir.i.imm[11]}}, ir.i.imm};
    wb_sel    = WB_ALU;
    reg_write = 1'b0;
    is_branch = 1'b0;
    is_load   = 1'b0;
    is_store  = 1'b0;
    is_jal    = 1'b0;
    is_jalr   = 1'b0;
    is_ecall  = 1'b0;
    case (ir.r.opcode)
      OPC_LUI: begin
        alu_op    = ALU_PASS_B;
        imm       = {ir.u.imm, 12'b0};
        reg_write = 1'b1;
      end
      OPC_AUIPC: begin
        op_a_pc   = 1'b1;
        imm       = {ir.u.imm, 12'b0};
        reg_write = 1'b1;
      end
      OPC_JAL: begin
        op_a_pc   = 1'b1;
        imm       = {{11{ir.j.imm_20}}, ir.j.imm_20, ir.j.imm_19_12, ir.j.imm_11,
                     ir.j.imm_10_1, 1'b0};
        wb_sel    = WB_PC_PLUS4;
        reg_write = 1'b1;
        is_jal    = 1'b1;
      end
      OPC_JALR: begin
        wb_sel    = WB_PC_PLUS4;
        reg_write = 1'b1;
        is_jalr   = 1'b1;
      end
      OPC_BRANCH: begin
        // alu forms the target, compare runs beside it
        op_a_pc   = 1'b1;
        imm       = {{19{ir.b.imm_12}}, ir.b.imm_12, ir.b.imm_11, ir.b.imm_10_5,
                     ir.b.imm_4_1, 1'b0};
        is_branch = 1'b1;
      end
      OPC_LOAD: begin
        wb_sel  = WB_LOAD;
        is_load = 1'b1;
      end
      OPC_STORE: begin
        imm      = {{20{ir.s.imm_hi[6]}}, ir.s.imm_hi, ir.s.imm_lo};
        is_store = 1'b1;
      end
      OPC_OP_IMM: begin
        alu_op    = alu_from_funct(ir.r.funct3, ir.r.funct7[5], 1'b0);
        reg_write = 1'b1;
      end
      OPC_OP: begin
        alu_op    = alu_from_funct(ir.r.funct3, ir.r.funct7[5], 1'b1);
        op_b_imm  = 1'b0;
        reg_write = 1'b1;
      end
      OPC_SYSTEM: is_ecall = 1'b1;
      default: ;
    endcase
  end

  always_comb begin
    if (is_jal || branch_taken) begin
      next_pc = alu_result;
    end else if (is_jalr) begin
      next_pc = {alu_result[31:1], 1'b0};
    end else begin
      next_pc = pc_plus4;
    end
  end

  // write-back select
  always_comb begin
    case (wb_sel)
      WB_LOAD:     rd_wdata = load_data;
      WB_PC_PLUS4: rd_wdata = pc_plus4;
      default:     rd_wdata = alu_result;
    endcase
  end

  assign rd_we     = (state == CORE_EXEC && reg_write) ||
                     (state == CORE_MEM && mem_done && is_load);
  assign mem_req   = (state == CORE_EXEC) && (is_load || is_store);
  assign mem_write = is_store;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= CORE_FETCH;
      pc    <= RESET_PC;
    end else begin
      case (state)
        CORE_FETCH: state <= CORE_EXEC;
        CORE_EXEC: begin
          if (is_ecall) begin
            // pc stays on the ecall
            state <= CORE_HALT;
          end else if (is_load || is_store) begin
            state <= CORE_MEM;
          end else begin
            pc    <= next_pc;
            state <= CORE_FETCH;
          end
        end
        CORE_MEM: begin
          if (mem_done) begin
            pc    <= pc_plus4;
            state <= CORE_FETCH;
          end
        end
        default: state <= CORE_HALT;
      endcase
    end
  end

  // instruction register loads at the end of fetch
  always_ff @(posedge clk) begin
    if (state == CORE_FETCH) begin
      ir <= imem_rdata;
    end
  end

endmodule

/* rv_isa_pkg.sv */
package rv_isa_pkg;

  // major opcodes, bits [6:0] of the instruction word
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_SYSTEM = 7'b1110011
  } opcode_t;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
  } alu_op_t;

  // register write-back source
  typedef enum logic [1:0] {
    WB_ALU,
    WB_LOAD,
    WB_PC_PLUS4
  } wb_sel_t;

  // funct3 for register and immediate ALU ops
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // funct3 for conditional branches
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcode_t    opcode;
  } r_type_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    opcode_t     opcode;
  } i_type_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    opcode_t    opcode;
  } s_type_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    opcode_t    opcode;
  } b_type_t;

  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    opcode_t     opcode;
  } u_type_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    opcode_t    opcode;
  } j_type_t;

  // one fetched word, seen through each encoding format
  typedef union packed {
    r_type_t r;
    i_type_t i;
    s_type_t s;
    b_type_t b;
    u_type_t u;
    j_type_t j;
  } instr_u;

endpackage

/* rv_lsu_apb.sv */
`timescale 1ns/100ps

module rv_lsu_apb (
  input  logic              clk,
  input  logic              reset,
  input  logic              mem_req,
  input  logic              mem_write,
  input  rv_soc_pkg::addr_t mem_addr,
  input  rv_soc_pkg::word_t store_data,
  output logic              mem_done,
  output rv_soc_pkg::word_t load_data,
  output rv_soc_pkg::addr_t paddr,
  output logic              psel,
  output logic              penable,
  output logic              pwrite,
  output rv_soc_pkg::word_t pwdata,
  input  rv_soc_pkg::word_t prdata,
  input  logic              pready
);
  import rv_soc_pkg::*;

  logic [1:0] state;
  addr_t      addr_q;
  word_t      wdata_q;
  logic       write_q;
  logic       req_accept;
  logic       xfer_end;

  assign req_accept = (state == LSU_IDLE) && mem_req;
  assign xfer_end   = (state == LSU_ACCESS) && pready;

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= LSU_IDLE;
      write_q  <= 1'b0;
      mem_done <= 1'b0;
    end else begin
      mem_done <= xfer_end;
      case (state)
        LSU_IDLE: begin
          if (mem_req) begin
            write_q <= mem_write;
            state   <= LSU_SETUP;
          end
        end
        LSU_SETUP: state <= LSU_ACCESS;
        LSU_ACCESS: begin
          // wait states hold everything here
          if (pready) begin
            state <= LSU_IDLE;
          end
        end
        default: state <= LSU_IDLE;
      endcase
    end
  end

  // address and data held for the whole transfer
  always_ff @(posedge clk) begin
    if (req_accept) begin
      addr_q  <= mem_addr;
      wdata_q <= store_data;
    end
    if (xfer_end && !write_q) begin
      load_data <= prdata;
    end
  end

  assign psel    = (state != LSU_IDLE);
  assign penable = (state == LSU_ACCESS);
  assign paddr   = addr_q;
  assign pwrite  = write_q;
  assign pwdata  = wdata_q;

endmodule

/* rv_regfile.sv */
`timescale 1ns/100ps

module rv_regfile (
  input  logic                 clk,
  input  logic                 reset,
  input  rv_soc_pkg::reg_idx_t rs1,
  input  rv_soc_pkg::reg_idx_t rs2,
  input  rv_soc_pkg::reg_idx_t rd,
  input  logic                 rd_we,
  input  rv_soc_pkg::word_t    rd_wdata,
  output rv_soc_pkg::word_t    rs1_data,
  output rv_soc_pkg::word_t    rs2_data
);
  import rv_soc_pkg::*;

  // x0 has no storage
  word_t regs [1:NUM_REGS-1];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 1; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (rd_we && rd != '0) begin
      regs[rd] <= rd_wdata;
    end
  end

  // async read ports
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* rv_soc_pkg.sv */
package rv_soc_pkg;

  localparam int XLEN       = 32;
  localparam int APB_ADDR_W = 32;
  localparam int REG_IDX_W  = 5;
  localparam int NUM_REGS   = 32;

  typedef logic [XLEN-1:0]       word_t;
  typedef logic [APB_ADDR_W-1:0] addr_t;
  typedef logic [REG_IDX_W-1:0]  reg_idx_t;

  // first instruction fetched after reset
  localparam addr_t RESET_PC = 32'h0000_0000;

  // core sequencer states
  localparam logic [1:0] CORE_FETCH = 2'd0;
  localparam logic [1:0] CORE_EXEC  = 2'd1;
  localparam logic [1:0] CORE_MEM   = 2'd2;
  localparam logic [1:0] CORE_HALT  = 2'd3;

  // apb master states
  localparam logic [1:0] LSU_IDLE   = 2'd0;
  localparam logic [1:0] LSU_SETUP  = 2'd1;
  localparam logic [1:0] LSU_ACCESS = 2'd2;

endpackage

/* tb_rv_core.sv */
`timescale 1ns/100ps

module tb_rv_core;
  import rv_soc_pkg::*;
  import rv_isa_pkg::*;

  localparam int GOLDEN_WORDS = 512;
  localparam int PROG_BASE    = 'h000;
  localparam int DATA_BASE    = 'h100;
  localparam int STORE_BASE   = 'h180;
  localparam int HALT_SLOT    = 'h1ff;
  localparam int MEM_WORDS    = 256;
  localparam int MAX_STORES   = 64;
  localparam int WATCH_CYCLES = 20;

  logic  clk = 1'b0;
  logic  reset;
  addr_t imem_addr;
  word_t imem_rdata;
  addr_t paddr;
  logic  psel;
  logic  penable;
  logic  pwrite;
  word_t pwdata;
  word_t prdata = '0;
  logic  pready = 1'b0;
  logic  halt;

  word_t       golden [0:GOLDEN_WORDS-1];
  word_t       imem [0:MEM_WORDS-1];
  word_t       dmem [0:MEM_WORDS-1];
  addr_t       exp_addr [0:MAX_STORES-1];
  word_t       exp_data [0:MAX_STORES-1];
  addr_t       halt_pc;
  int          num_prog;
  int          num_stores;
  int          store_count = 0;
  int          cycle_count = 0;
  int          cycle_limit = 0;
  logic [31:0] rng = 32'd47643;
  logic [1:0]  waits_left;

  rv_core i_rv_core (
    .clk        (clk),
    .reset      (reset),
    .imem_addr  (imem_addr),
    .imem_rdata (imem_rdata),
    .paddr      (paddr),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pready     (pready),
    .halt       (halt)
  );

  always #10 clk = ~clk;

  // instruction memory answers combinationally
  assign imem_rdata = imem[imem_addr[9:2]];

  task automatic fail_run();
    $display("Finished with errors");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_store(input string name, input addr_t exp_a, input word_t exp_d,
                             input addr_t act_a, input word_t act_d);
    if (act_a !== exp_a || act_d !== exp_d) begin
      $display("FAIL %s expected %h <= %h actual %h <= %h", name, exp_a, exp_d, act_a, act_d);
      fail_run();
    end
  endtask

  task automatic check_pc(input string name, input addr_t exp_pc, input addr_t act_pc);
    if (act_pc !== exp_pc) begin
      $display("FAIL %s expected %h actual %h", name, exp_pc, act_pc);
      fail_run();
    end
  endtask

  task automatic check_bit(input string name, input logic exp_v, input logic act_v);
    if (act_v !== exp_v) begin
      $display("FAIL %s expected %b actual %b", name, exp_v, act_v);
      fail_run();
    end
  endtask

  task automatic check_reset_outputs(input string when);
    check_bit({when, " psel"}, 1'b0, psel);
    check_bit({when, " penable"}, 1'b0, penable);
    check_bit({when, " halt"}, 1'b0, halt);
    check_pc({when, " imem_addr"}, RESET_PC, imem_addr);
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // fill for words the golden file leaves unset
  function automatic word_t fill_word(input addr_t a);
    return a ^ 32'h5a5a_a5a5;
  endfunction

  task automatic load_golden();
    int    mem_ops;
    int    num_data;
    addr_t a;
    word_t instr;
    mem_ops = 0;
    for (int i = 0; i < GOLDEN_WORDS; i++) begin
      golden[i] = '0;
    end
    $readmemh("rv_core_golden.txt", golden);
    num_prog   = golden[PROG_BASE];
    num_data   = golden[DATA_BASE];
    num_stores = golden[STORE_BASE];
    if (num_prog == 0 || num_prog > MEM_WORDS || num_stores > MAX_STORES) begin
      $display("golden file is missing or its record counts are out of range");
      fail_run();
    end
    for (int i = 0; i < MEM_WORDS; i++) begin
      imem[i] = fill_word(i * 4);
      dmem[i] = fill_word(i * 4);
    end
    for (int i = 0; i < num_prog; i++) begin
      instr = golden[PROG_BASE + 1 + i];
      imem[i] = instr;
      if (instr[6:0] == OPC_LOAD || instr[6:0] == OPC_STORE) begin
        mem_ops++;
      end
    end
    for (int i = 0; i < num_data; i++) begin
      a = golden[DATA_BASE + 1 + 2 * i];
      dmem[a[9:2]] = golden[DATA_BASE + 2 + 2 * i];
    end
    for (int i = 0; i < num_stores; i++) begin
      exp_addr[i] = golden[STORE_BASE + 1 + 2 * i];
      exp_data[i] = golden[STORE_BASE + 2 + 2 * i];
    end
    halt_pc = golden[HALT_SLOT];
    // two cycles per instruction, memory ops add 3 cycles and up to 3 waits
    cycle_limit = num_prog * 2 + mem_ops * 6 + 100;
  endtask

  // apb slave with 0 to 3 random wait states
  always @(posedge clk) begin
    if (reset) begin
      pready     <= 1'b0;
      waits_left <= 2'd0;
    end else if (psel && !penable) begin
      if (paddr[31:10] != '0 || paddr[1:0] != 2'b00) begin
        $display("apb address %h is outside the data memory or not word aligned", paddr);
        fail_run();
      end
      rng = xorshift32(rng);
      waits_left <= rng[1:0];
      pready     <= (rng[1:0] == 2'd0);
      if (!pwrite) begin
        prdata <= dmem[paddr[9:2]];
      end
    end else if (psel && penable) begin
      if (pready) begin
        pready <= 1'b0;
        if (pwrite) begin
          if (store_count >= num_stores) begin
            $display("unexpected store of %h to %h", pwdata, paddr);
            fail_run();
          end
          check_store($sformatf("store %0d", store_count), exp_addr[store_count],
                      exp_data[store_count], paddr, pwdata);
          dmem[paddr[9:2]] <= pwdata;
          store_count <= store_count + 1;
        end
      end else begin
        waits_left <= waits_left - 2'd1;
        pready     <= (waits_left == 2'd1);
      end
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      $display("timeout after %0d cycles without the run finishing", cycle_limit);
      fail_run();
    end
  end

  always @(negedge clk) begin
    if (i_rv_core.i_apb_assert.assert_failed) begin
      $display("an apb protocol or halt assertion failed");
      fail_run();
    end
  end

  initial begin
    reset <= 1'b1;
    load_golden();
    @(posedge clk);
    repeat (7) begin
      @(negedge clk);
      check_reset_outputs("in reset");
      @(posedge clk);
    end
    reset <= 1'b0;
    @(negedge clk);
    check_reset_outputs("after reset");

    while (halt !== 1'b1) begin
      @(negedge clk);
    end
    check_pc("halt pc", halt_pc, imem_addr);

    // core must stay frozen and the bus quiet
    repeat (WATCH_CYCLES) begin
      @(negedge clk);
      if (psel !== 1'b0) begin
        $display("apb transfer started after halt");
        fail_run();
      end
      check_pc("pc after halt", halt_pc, imem_addr);
    end

    if (store_count != num_stores) begin
      $display("only %0d of %0d expected stores were seen", store_count, num_stores);
      fail_run();
    end else begin
      $display("Finished with no errors");
      $finish;
    end
  end

endmodule

/* tb_rv_core_assert.sv */
`timescale 1ns/100ps

module rv_core_apb_assert (
  input logic              clk,
  input logic              reset,
  input rv_soc_pkg::addr_t paddr,
  input logic              psel,
  input logic              penable,
  input logic              pwrite,
  input rv_soc_pkg::word_t pwdata,
  input logic              pready,
  input logic              halt
);
  logic setup_err = 1'b0;
  logic access_err = 1'b0;
  logic stable_err = 1'b0;
  logic idle_err = 1'b0;
  logic halt_err = 1'b0;
  logic assert_failed;

  assign assert_failed = setup_err | access_err | stable_err | idle_err | halt_err;

  // setup lasts exactly one cycle
  setup_to_access: assert property (@(posedge clk) disable iff (reset)
      (psel && !penable) |=> (psel && penable))
    else begin
      setup_err = 1'b1;
      $error("setup cycle not followed by access");
    end

  access_after_setup: assert property (@(posedge clk) disable iff (reset)
      $rose(penable) |-> $past(psel && !penable))
    else begin
      access_err = 1'b1;
      $error("access phase without a setup cycle");
    end

  // address, direction and write data hold until pready
  hold_while_waiting: assert property (@(posedge clk) disable iff (reset)
      (psel && !(penable && pready)) |=>
        (psel && $stable(paddr) && $stable(pwrite) && $stable(pwdata)))
    else begin
      stable_err = 1'b1;
      $error("apb transfer changed before completion");
    end

  idle_after_transfer: assert property (@(posedge clk) disable iff (reset)
      (psel && penable && pready) |=> !psel)
    else begin
      idle_err = 1'b1;
      $error("psel not dropped after a completed transfer");
    end

  no_psel_when_halted: assert property (@(posedge clk) disable iff (reset)
      halt |-> !psel)
    else begin
      halt_err = 1'b1;
      $error("apb transfer while the core is halted");
    end

endmodule

bind rv_core rv_core_apb_assert i_apb_assert (
  .clk     (clk),
  .reset   (reset),
  .paddr   (paddr),
  .psel    (psel),
  .penable (penable),
  .pwrite  (pwrite),
  .pwdata  (pwdata),
  .pready  (pready),
  .halt    (halt)
);
